//--- aes_cbc_enc.f
hw/aes_pkg.sv
hw/aes_cmd_pkg.sv
hw/aes_key_expand.sv
hw/aes_round_datapath.sv
hw/aes_enc_ctrl.sv
hw/aes_cbc_chain.sv
hw/aes_cbc_enc.sv
verif/tb_aes_cbc_enc.sv

//--- hw/aes_cbc_chain.sv
// cbc chaining register and output select
// holds iv, last ciphertext or last nop word
`timescale 1ns/1ns
`default_nettype none

module aes_cbc_chain (
   input  logic              clk,
   input  logic              first_pkt,
   input  logic              text_load,
   input  logic              text_ready,
   input  aes_cmd_pkg::cmd_t cmd,
   input  aes_pkg::block_t   text_in,
   input  aes_pkg::block_t   aes_iv,
   input  aes_pkg::block_t   cipher_state,
   output aes_pkg::block_t   chain_iv,
   output aes_pkg::block_t   text_out
);
   import aes_cmd_pkg::*;

   logic is_enc;

   assign is_enc = (cmd == CMD_ENC);

   always_ff @(posedge clk) begin
      if (first_pkt)
         chain_iv <= aes_iv;        // new session
      else if (text_ready && is_enc)
         chain_iv <= cipher_state;  // ciphertext feeds next block
      else if (text_load && !is_enc)
         chain_iv <= text_in;       // nop word also chains
   end

   // nop loops the loaded word back out
   assign text_out = is_enc ? cipher_state : chain_iv;

endmodule

`default_nettype wire

//--- hw/aes_cbc_enc.sv
// CBC-mode AES-128 encrypt engine with nop pass-through
// key schedule, round datapath, control and chaining
`timescale 1ns/1ns
`default_nettype none

module aes_cbc_enc (
   input  logic              clk,
   input  logic              rst,
   input  logic              text_load,
   input  logic              first_pkt,
   input  aes_cmd_pkg::cmd_t cmd,
   input  aes_pkg::block_t   text_in,
   input  aes_pkg::block_t   secret_key,
   input  aes_pkg::block_t   aes_iv,
   output aes_pkg::block_t   text_out,
   output logic              text_ready
);
   import aes_pkg::*;

   logic   enc_go, enc_start, enc_work, enc_done;  // round strobes
   block_t round_key;
   block_t cipher_state;
   block_t chain_iv;

   aes_enc_ctrl u_ctrl (
      .clk        (clk),
      .rst        (rst),
      .text_load  (text_load),
      .cmd        (cmd),
      .enc_go     (enc_go),
      .enc_start  (enc_start),
      .enc_work   (enc_work),
      .enc_done   (enc_done),
      .text_ready (text_ready)
   );

   aes_key_expand u_key (
      .clk        (clk),
      .enc_work   (enc_work),
      .secret_key (secret_key),
      .round_key  (round_key)
   );

   aes_round_datapath u_dp (
      .clk          (clk),
      .enc_go       (enc_go),
      .enc_start    (enc_start),
      .enc_work     (enc_work),
      .enc_done     (enc_done),
      .text_in      (text_in),
      .chain_iv     (chain_iv),
      .round_key    (round_key),
      .cipher_state (cipher_state)
   );

   aes_cbc_chain u_chain (
      .clk          (clk),
      .first_pkt    (first_pkt),
      .text_load    (text_load),
      .text_ready   (text_ready),
      .cmd          (cmd),
      .text_in      (text_in),
      .aes_iv       (aes_iv),
      .cipher_state (cipher_state),
      .chain_iv     (chain_iv),
      .text_out     (text_out)
   );

endmodule

`default_nettype wire

//--- hw/aes_cmd_pkg.sv
// command encoding and round schedule constants
`default_nettype none

package aes_cmd_pkg;

   // 0x nop, 10 encrypt, 11 decrypt code (runs as nop here)
   typedef logic [1:0] cmd_t;

   localparam cmd_t CMD_ENC = 2'b10;

   localparam int NUM_ROUNDS = 10;  // aes-128 only

   // round constant sequence 01..80, then 1b, 36
   localparam logic [7:0] RCON_FIRST     = 8'h01;
   localparam logic [7:0] RCON_WRAP      = 8'h1b;  // after 80
   localparam logic [7:0] RCON_LAST_MARK = 8'h36;  // round 10

endpackage

`default_nettype wire

//--- hw/aes_enc_ctrl.sv
// encrypt sequencing: run/start/work/done strobes and round counter
// text_ready pulses at the end of an encrypt or after a nop load
`timescale 1ns/1ns
`default_nettype none

module aes_enc_ctrl (
   input  logic              clk,
   input  logic              rst,
   input  logic              text_load,
   input  aes_cmd_pkg::cmd_t cmd,
   output logic              enc_go,
   output logic              enc_start,
   output logic              enc_work,
   output logic              enc_done,
   output logic              text_ready
);
   import aes_cmd_pkg::*;

   localparam logic [3:0] CNT_LOAD = 4'(NUM_ROUNDS + 1);

   logic       enc_run;   // block in flight
   logic       enc_last;  // last full round
   logic       nop_go;    // load that bypasses the cipher
   logic [3:0] cnt;

   assign enc_go   = text_load & (cmd == CMD_ENC);
   assign nop_go   = text_load & (cmd != CMD_ENC);  // decrypt code lands here too
   assign enc_last = enc_work & (cnt == 4'd1);

   always_ff @(posedge clk) begin
      if (rst) begin
         enc_run    <= 1'b0;
         enc_start  <= 1'b0;
         enc_work   <= 1'b0;
         enc_done   <= 1'b0;
         cnt        <= 4'd0;
         text_ready <= 1'b0;
      end else begin
         enc_run    <= enc_go | (enc_run & ~enc_last);
         enc_start  <= enc_run & ~enc_work;  // one cycle after go
         enc_work   <= enc_run;
         enc_done   <= enc_last;
         text_ready <= enc_done | nop_go;
         if (enc_go)
            cnt <= CNT_LOAD;
         else if (enc_run)
            cnt <= cnt - 4'd1;
      end
   end

   a_ready_pulse : assert property (@(posedge clk) disable iff (rst)
      text_ready |=> !text_ready);

   // one block at a time, no back-pressure
   a_no_overlap : assert property (@(posedge clk) disable iff (rst)
      enc_run |-> !text_load);

endmodule

`default_nettype wire

//--- hw/aes_key_expand.sv
// AES-128 key schedule, one round key per cycle
// reloads from secret_key whenever the cipher is idle
`timescale 1ns/1ns
`default_nettype none

module aes_key_expand (
   input  logic            clk,
   input  logic            enc_work,
   input  aes_pkg::block_t secret_key,
   output aes_pkg::block_t round_key
);
   import aes_pkg::*;
   import aes_cmd_pkg::*;

   word_t      w0, w1, w2, w3;      // w0 is the leftmost key word
   word_t      n0, n1, n2, n3;      // next round key words
   word_t      sub_rot;             // SubWord(RotWord(w3))
   logic [7:0] rcon;                // shift reg, doubles as round decode

   assign sub_rot = {sbox(w3[23:16]), sbox(w3[15:8]), sbox(w3[7:0]), sbox(w3[31:24])};

   assign n0 = w0 ^ sub_rot ^ {rcon, 24'd0};
   assign n1 = n0 ^ w1;
   assign n2 = n1 ^ w2;
   assign n3 = n2 ^ w3;

   assign round_key = {w0, w1, w2, w3};

   always_ff @(posedge clk) begin
      if (!enc_work) begin
         {w0, w1, w2, w3} <= secret_key;  // idle, hold round 0 key
         rcon             <= RCON_FIRST;
      end else begin
         w0 <= n0;
         w1 <= n1;
         w2 <= n2;
         w3 <= n3;
         if (rcon == RCON_LAST_MARK)
            rcon <= 8'h00;                // schedule done
         else if (rcon[7])
            rcon <= RCON_WRAP;            // gf reduction
         else
            rcon <= {rcon[6:0], 1'b0};
      end
   end

   // legal values: zero or one of the NUM_ROUNDS constants
   function automatic logic rcon_legal(input logic [7:0] r);
      logic [7:0] c;
      logic       ok;
      int         i;
      c  = RCON_FIRST;
      ok = (r == 8'h00);
      for (i = 0; i < NUM_ROUNDS; i++) begin
         ok |= (r == c);
         c = c[7] ? RCON_WRAP : {c[6:0], 1'b0};
      end
      return ok;
   endfunction

   a_rcon_legal : assert property (@(posedge clk) !$isunknown(rcon) |-> rcon_legal(rcon));

   // last constant lines up with the final round of the control sequence
   a_rcon_last : assert property (@(posedge clk)
      $rose(enc_work) |-> ##(NUM_ROUNDS - 1) (rcon == RCON_LAST_MARK));

endmodule

`default_nettype wire

//--- hw/aes_pkg.sv
// AES data-path definitions
// block and word types, the two-way state view and the forward S-box
`default_nettype none

package aes_pkg;

   typedef logic [127:0] block_t;  // text, iv, key or state
   typedef logic [31:0]  word_t;   // key schedule word or state column

   // one state word, seen as bytes or as columns
   typedef union packed {
      logic [15:0][7:0] bytes;  // bytes[15] is AES byte 0
      word_t [3:0]      cols;   // cols[3] is AES column 0
   } aes_state_u;

   // forward substitution table, entry 0 in the top byte
   localparam logic [0:255][7:0] SBOX_TABLE = {
      128'h637c777bf26b6fc53001672bfed7ab76,
      128'hca82c97dfa5947f0add4a2af9ca472c0,
      128'hb7fd9326363ff7cc34a5e5f171d83115,
      128'h04c723c31896059a071280e2eb27b275,
      128'h09832c1a1b6e5aa0523bd6b329e32f84,
      128'h53d100ed20fcb15b6acbbe394a4c58cf,
      128'hd0efaafb434d338545f9027f503c9fa8,
      128'h51a3408f929d38f5bcb6da2110fff3d2,
      128'hcd0c13ec5f974417c4a77e3d645d1973,
      128'h60814fdc222a908846eeb814de5e0bdb,
      128'he0323a0a4906245cc2d3ac629195e479,
      128'he7c8376d8dd54ea96c56f4ea657aae08,
      128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
      128'h703eb5664803f60e613557b986c11d9e,
      128'he1f8981169d98e949b1e87e9ce5528df,
      128'h8ca1890dbfe6426841992d0fb054bb16
   };

   // single byte substitution
   function automatic logic [7:0] sbox(input logic [7:0] a);
      return SBOX_TABLE[a];
   endfunction

endpackage

`default_nettype wire

//--- hw/aes_round_datapath.sv
// AES encrypt state register and round logic
// cbc xor on load, then 10 rounds with live round keys
`timescale 1ns/1ns
`default_nettype none

module aes_round_datapath (
   input  logic            clk,
   input  logic            enc_go,
   input  logic            enc_start,
   input  logic            enc_work,
   input  logic            enc_done,
   input  aes_pkg::block_t text_in,
   input  aes_pkg::block_t chain_iv,
   input  aes_pkg::block_t round_key,
   output aes_pkg::block_t cipher_state
);
   import aes_pkg::*;

   aes_state_u st;   // current state
   aes_state_u sub;  // after SubBytes
   aes_state_u sr;   // after ShiftRows
   aes_state_u mix;  // after MixColumns

   // multiply by x in GF(2^8)
   function automatic logic [7:0] xtime(input logic [7:0] b);
      return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
   endfunction

   // one column times the fixed 02 03 01 01 matrix
   function automatic word_t mix_col(input word_t c);
      logic [7:0] a0, a1, a2, a3;
      a0 = c[31:24];  // row 0
      a1 = c[23:16];
      a2 = c[15:8];
      a3 = c[7:0];
      return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
              a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
              a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
              xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
   endfunction

   assign st = cipher_state;

   always_comb begin
      for (int n = 0; n < 16; n++)
         sub.bytes[n] = sbox(st.bytes[n]);
   end

   // aes byte 4c+r comes from column c+r of the same row
   always_comb begin
      for (int c = 0; c < 4; c++) begin
         for (int r = 0; r < 4; r++)
            sr.bytes[15 - (4 * c + r)] = sub.bytes[15 - (4 * ((c + r) % 4) + r)];
      end
   end

   always_comb begin
      for (int j = 0; j < 4; j++)
         mix.cols[j] = mix_col(sr.cols[j]);
   end

   always_ff @(posedge clk) begin
      if (enc_go)
         cipher_state <= text_in ^ chain_iv;      // cbc step
      else if (enc_start)
         cipher_state <= cipher_state ^ round_key; // initial AddRoundKey
      else if (enc_done)
         cipher_state <= sr ^ round_key;           // round 10, no mix
      else if (enc_work)
         cipher_state <= mix ^ round_key;          // rounds 1..9
   end

endmodule

`default_nettype wire

//--- run_sim.sh
#!/bin/sh
# build and run the cbc aes-128 testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f aes_cbc_enc.f --top-module tb_aes_cbc_enc -o sim_tb
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit $status
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit $status
fi

exit 0

//--- verif/tb_aes_cbc_enc.sv
// testbench for the cbc aes-128 encrypt engine
// sp 800-38a and fips-197 known answers, nop pass-through and nop chaining
`timescale 1ns/1ns
`default_nettype none

module tb_aes_cbc_enc;
   import aes_pkg::*;

   localparam logic [1:0] NOP_00 = 2'b00;
   localparam logic [1:0] NOP_01 = 2'b01;
   localparam logic [1:0] ENC    = 2'b10;
   localparam logic [1:0] DEC_11 = 2'b11;  // decrypt code, runs as nop

   localparam block_t KEY_SP   = 128'h2b7e151628aed2a6abf7158809cf4f3c;
   localparam block_t IV_SP    = 128'h000102030405060708090a0b0c0d0e0f;
   localparam block_t KEY_FIPS = 128'h000102030405060708090a0b0c0d0e0f;
   localparam block_t IV_ZERO  = 128'h0;

   // one table row
   typedef struct {
      string      name;
      logic [1:0] cmd;
      logic       first;    // pulse first_pkt before the load
      block_t     key;
      block_t     iv;
      block_t     text;
      block_t     exp_out;  // expected text_out at text_ready
   } vector_t;

   logic       clk;
   logic       rst;
   logic       text_load;
   logic       first_pkt;
   logic [1:0] cmd;
   block_t     text_in;
   block_t     secret_key;
   block_t     aes_iv;
   block_t     text_out;
   logic       text_ready;

   vector_t vectors[$];
   int      cycle_count = 0;
   int      cycle_limit = 0;  // set once the table is built

   aes_cbc_enc DUT (
      .clk        (clk),
      .rst        (rst),
      .text_load  (text_load),
      .first_pkt  (first_pkt),
      .cmd        (cmd),
      .text_in    (text_in),
      .secret_key (secret_key),
      .aes_iv     (aes_iv),
      .text_out   (text_out),
      .text_ready (text_ready)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;  // 8 ns period
   end

   // run limit, 20 cycles per row plus 50
   initial begin
      wait (cycle_limit > 0);
      while (cycle_count < cycle_limit) begin
         @(posedge clk);
         cycle_count++;
      end
      $display("timeout: text_ready never came, run stopped after %0d cycles", cycle_count);
      $display("SIMULATION FAILED");
      $fatal(1, "run aborted by the cycle limit");
   end

   task automatic add_vector(input string name, input logic [1:0] c, input logic first,
                             input block_t key, input block_t iv, input block_t text,
                             input block_t exp_out);
      vector_t v;
      v.name    = name;
      v.cmd     = c;
      v.first   = first;
      v.key     = key;
      v.iv      = iv;
      v.text    = text;
      v.exp_out = exp_out;
      vectors.push_back(v);
   endtask

   task automatic check_value(input string name, input logic [127:0] expected,
                              input logic [127:0] actual);
      if (actual !== expected) begin
         $display("Fail %s: expected %h, actual %h", name, expected, actual);
         $display("SIMULATION FAILED");
         $fatal(1, "stopped at the first mismatch");
      end
   endtask

   task automatic apply_vector(input vector_t v);
      int unsigned gap;
      gap = $urandom % 4;  // 0..3 idle cycles
      repeat (gap) begin
         @(negedge clk);
         check_value({v.name, " idle ready"}, 128'd0, 128'(text_ready));
      end
      @(posedge clk);
      #1;
      cmd        = v.cmd;  // held until the next row
      secret_key = v.key;  // reloads while the cipher is idle
      aes_iv     = v.iv;
      text_in    = v.text;
      if (v.first) begin
         first_pkt = 1'b1;  // iv into chain, one cycle ahead
         @(posedge clk);
         #1;
         first_pkt = 1'b0;
      end
      text_load = 1'b1;
      @(posedge clk);
      #1;
      text_load = 1'b0;
      @(negedge clk);
      while (text_ready !== 1'b1)
         @(negedge clk);
      check_value(v.name, v.exp_out, text_out);
      @(negedge clk);
      check_value({v.name, " single ready pulse"}, 128'd0, 128'(text_ready));
   endtask

   initial begin
      void'($urandom(52));
      rst        = 1'b1;
      text_load  = 1'b0;
      first_pkt  = 1'b0;
      cmd        = NOP_00;
      text_in    = '0;
      secret_key = '0;
      aes_iv     = '0;

      // sp 800-38a f.2.1, blocks 1 to 4
      add_vector("sp_cbc_blk1", ENC, 1'b1, KEY_SP, IV_SP,
                 128'h6bc1bee22e409f96e93d7e117393172a, 128'h7649abac8119b246cee98e9b12e9197d);
      add_vector("sp_cbc_blk2", ENC, 1'b0, KEY_SP, IV_SP,
                 128'hae2d8a571e03ac9c9eb76fac45af8e51, 128'h5086cb9b507219ee95db113a917678b2);
      add_vector("sp_cbc_blk3", ENC, 1'b0, KEY_SP, IV_SP,
                 128'h30c81c46a35ce411e5fbc1191a0a52ef, 128'h73bed6b8e3c1743b7116e69e22229516);
      add_vector("sp_cbc_blk4", ENC, 1'b0, KEY_SP, IV_SP,
                 128'hf69f2445df4f9b17ad2b417be66c3710, 128'h3ff1caa1681fac09120eca307586e1a7);
      // nop loops text straight back
      add_vector("nop_cmd00", NOP_00, 1'b0, KEY_SP, IV_SP,
                 128'h0123456789abcdeffedcba9876543210, 128'h0123456789abcdeffedcba9876543210);
      add_vector("nop_cmd11", DEC_11, 1'b0, KEY_SP, IV_SP,
                 128'hdeadbeef00c0ffee5a5aa5a512345678, 128'hdeadbeef00c0ffee5a5aa5a512345678);
      // nop word W = blk1 ciphertext, then blk2 chains on it
      add_vector("nop_chain_w", NOP_00, 1'b0, KEY_SP, IV_SP,
                 128'h7649abac8119b246cee98e9b12e9197d, 128'h7649abac8119b246cee98e9b12e9197d);
      add_vector("enc_after_nop", ENC, 1'b0, KEY_SP, IV_SP,
                 128'hae2d8a571e03ac9c9eb76fac45af8e51, 128'h5086cb9b507219ee95db113a917678b2);
      // fips-197 c.1, new key and zero iv
      add_vector("fips197_blk", ENC, 1'b1, KEY_FIPS, IV_ZERO,
                 128'h00112233445566778899aabbccddeeff, 128'h69c4e0d86a7b0430d8cdb78070b4c55a);
      add_vector("nop_cmd01", NOP_01, 1'b0, KEY_FIPS, IV_ZERO,
                 128'hfedcba98765432100f1e2d3c4b5a6978, 128'hfedcba98765432100f1e2d3c4b5a6978);

      cycle_limit = 20 * vectors.size() + 50;

      repeat (10) begin
         @(posedge clk);
         #1;
         check_value("ready low in reset", 128'd0, 128'(text_ready));
      end
      rst = 1'b0;
      repeat (2) begin
         @(negedge clk);
         check_value("ready low after reset", 128'd0, 128'(text_ready));
      end

      foreach (vectors[i])
         apply_vector(vectors[i]);

      $display("SIMULATION PASSED");
      $finish;
   end

endmodule

`default_nettype wire
